/* verilog/taillight_timing_pkg.sv */
`default_nettype none

// sweep rate of the tail lights
package taillight_timing_pkg;

    // ============================================================
    // step divider
    // ============================================================

    // one step lasts 2**step_div_bits clk_en cycles
    localparam int step_div_bits = 4;              // short for simulation, board needs ~24

    localparam int step_period = 2 ** step_div_bits; // cycles per lamp step

    typedef logic [step_div_bits-1:0] step_count_t; // divider count

    localparam step_count_t step_last = '1;        // count that issues the tick

endpackage

`default_nettype wire

/* verilog/taillight_lamp_pkg.sv */
`default_nettype none

// lamp side of the tail lights
package taillight_lamp_pkg;

    // ============================================================
    // lamp pattern
    // ============================================================

    localparam int lamp_count = 3;                 // lamps per side

    // bit 0 sits nearest the car center
    typedef logic [lamp_count-1:0] lamp_pattern_t;

    // ============================================================
    // sweep FSM
    // ============================================================

    typedef enum logic [1:0] {
        sweep_off   = 2'd0,                        // all dark
        sweep_one   = 2'd1,                        // inner lamp
        sweep_two   = 2'd2,                        // inner two
        sweep_three = 2'd3                         // all lit
    } sweep_state_t;

    // state n lights the lowest n lamps
    function automatic lamp_pattern_t thermometer_of(input sweep_state_t state);
        return lamp_pattern_t'((1 << state) - 1);
    endfunction

endpackage

`default_nettype wire

/* verilog/step_timer.sv */
`timescale 1ns/1ns
`default_nettype none

// free-running divider, one tick per step period
module step_timer (
    input  wire  clk_en,
    input  wire  rst,
    output logic step_tick
);

    import taillight_timing_pkg::*;

    // ============================================================
    // divider
    // ============================================================

    step_count_t count;                            // wraps every step_period cycles

    always_ff @(posedge clk_en) begin
        if (rst) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;                 // wrap is the period
        end
    end

    // tick on the last count of the period
    assign step_tick = (count == step_last);

    // ============================================================
    // checks
    // ============================================================

    // a tick never stretches into the following cycle
    a_single_tick: assert property (
        @(posedge clk_en) disable iff (rst)
        step_tick |=> !step_tick
    ) else $error("step_tick high two cycles in a row");

endmodule

`default_nettype wire

/* verilog/turn_request.sv */
`timescale 1ns/1ns
`default_nettype none

// rising-edge latch for one turn input
// holds the press until the sequencer starts a sweep for it
module turn_request (
    input  wire  clk_en,
    input  wire  rst,
    input  wire  turn,
    input  wire  taken,
    output logic pending
);

    // ============================================================
    // edge detect
    // ============================================================

    logic turn_q;                                  // previous sample of turn
    logic turn_rise;                               // low to high this cycle

    always_ff @(posedge clk_en) begin
        if (rst) begin
            turn_q <= 1'b0;                        // a held input at reset counts as a press
        end else begin
            turn_q <= turn;
        end
    end

    assign turn_rise = turn && !turn_q;

    // ============================================================
    // pending flag
    // ============================================================

    // a new edge beats a taken in the same cycle
    always_ff @(posedge clk_en) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (turn_rise) begin
            pending <= 1'b1;                       // remember the press
        end else if (taken) begin
            pending <= 1'b0;                       // sweep started for it
        end
    end

endmodule

`default_nettype wire

/* verilog/lamp_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

// per-side sweep FSM
// steps off, one, two, three lamps, then dark again
module lamp_sequencer (
    input  wire                            clk_en,
    input  wire                            rst,
    input  wire                            step_tick,
    input  wire                            pending,
    input  wire                            held,
    output logic                           taken,
    output taillight_lamp_pkg::lamp_pattern_t lamps
);

    import taillight_lamp_pkg::*;

    // ============================================================
    // state machine
    // ============================================================

    sweep_state_t state;                           // current sweep step
    sweep_state_t state_next;

    always_comb begin
        state_next = state;
        taken      = 1'b0;
        if (step_tick) begin                       // nothing moves between ticks
            case (state)
                sweep_off: begin
                    if (pending || held) begin     // queued press or held input
                        state_next = sweep_one;
                        taken      = 1'b1;         // clears the request latch
                    end
                end
                sweep_one:   state_next = sweep_two;
                sweep_two:   state_next = sweep_three;
                sweep_three: state_next = sweep_off; // one dark step before a restart
                default:     state_next = sweep_off;
            endcase
        end
    end

    always_ff @(posedge clk_en) begin
        if (rst) begin
            state <= sweep_off;
        end else begin
            state <= state_next;
        end
    end

    // ============================================================
    // lamp register
    // ============================================================

    // follows the state one cycle late
    always_ff @(posedge clk_en) begin
        if (rst) begin
            lamps <= '0;
        end else begin
            lamps <= thermometer_of(state);
        end
    end

    // ============================================================
    // checks
    // ============================================================

    a_step_on_tick: assert property (
        @(posedge clk_en) disable iff (rst)
        !step_tick |=> $stable(state)
    ) else $error("sweep state moved without step_tick");

    // thermometer plus one is a single bit or wraps to zero
    a_thermometer: assert property (
        @(posedge clk_en) disable iff (rst)
        $onehot0(lamp_pattern_t'(lamps + 1'b1))
    ) else $error("lamp pattern is not a thermometer code");

endmodule

`default_nettype wire

/* verilog/taillight_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

// tail-light turn signal controller
// left and right sweep on their own, paced by one shared step timer
module taillight_ctrl (
    input  wire  clk_en,
    input  wire  rst,
    input  wire  left,
    input  wire  right,
    output logic la,
    output logic lb,
    output logic lc,
    output logic ra,
    output logic rb,
    output logic rc
);

    import taillight_lamp_pkg::*;

    logic          step_tick;                      // one cycle per step period
    logic          left_pending;
    logic          right_pending;
    logic          left_taken;
    logic          right_taken;
    lamp_pattern_t left_lamps;
    lamp_pattern_t right_lamps;

    // ============================================================
    // shared pacing
    // ============================================================

    step_timer step_timer_i (
        .clk_en    (clk_en),
        .rst       (rst),
        .step_tick (step_tick)
    );

    // ============================================================
    // left side
    // ============================================================

    turn_request left_request_i (
        .clk_en  (clk_en),
        .rst     (rst),
        .turn    (left),
        .taken   (left_taken),
        .pending (left_pending)
    );

    lamp_sequencer left_seq_i (
        .clk_en    (clk_en),
        .rst       (rst),
        .step_tick (step_tick),
        .pending   (left_pending),
        .held      (left),                         // raw level keeps a held lever sweeping
        .taken     (left_taken),
        .lamps     (left_lamps)
    );

    // ============================================================
    // right side
    // ============================================================

    turn_request right_request_i (
        .clk_en  (clk_en),
        .rst     (rst),
        .turn    (right),
        .taken   (right_taken),
        .pending (right_pending)
    );

    lamp_sequencer right_seq_i (
        .clk_en    (clk_en),
        .rst       (rst),
        .step_tick (step_tick),
        .pending   (right_pending),
        .held      (right),
        .taken     (right_taken),
        .lamps     (right_lamps)
    );

    // inner lamp is bit 0 on both sides so the sweep runs outward
    assign la = left_lamps[0];
    assign lb = left_lamps[1];
    assign lc = left_lamps[2];
    assign ra = right_lamps[0];
    assign rb = right_lamps[1];
    assign rc = right_lamps[2];

endmodule

`default_nettype wire

/* include/tb_util.svh */
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// testbench helpers, included inside the testbench module
// wait_lamp_change reads clk_en and la..rc of the including scope

localparam logic [31:0] lfsr_seed = 32'h5ec739d6;  // start value of the stimulus LFSR

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
endfunction

// stops the run on the first mismatch
task automatic check_equal(
    input string       test_name,
    input logic [31:0] expected,
    input logic [31:0] actual
);
    if (actual !== expected) begin
        $display("FAILED %s expected %0h actual %0h", test_name, expected, actual);
        $display("FAIL: see errors above");
        $fatal(1, "check_equal mismatch in %s", test_name);
    end
endtask

// returns just after the clk_en edge on which any lamp changed
task automatic wait_lamp_change(input string test_name);
    logic [5:0] start_lamps;
    int         cycles;
    start_lamps = {la, lb, lc, ra, rb, rc};
    cycles      = 0;
    while ({la, lb, lc, ra, rb, rc} === start_lamps) begin
        if (cycles >= 6 * taillight_timing_pkg::step_period) begin
            $display("timeout in %s, no lamp change within %0d cycles", test_name, cycles);
            $display("FAIL: see errors above");
            $fatal(1, "lamp wait timed out");
        end else begin
            @(posedge clk_en);
            #1;                                    // lamps settled after the edge
            cycles++;
        end
    end
endtask

`endif

/* tests/taillight_ctrl_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module taillight_ctrl_tb;

    import taillight_timing_pkg::*;

    logic        clk_en;
    logic        rst;
    logic        left;
    logic        right;
    wire         la;
    wire         lb;
    wire         lc;
    wire         ra;
    wire         rb;
    wire         rc;
    int          cycle;                            // clk_en edges since reset release
    logic [31:0] lfsr;                             // stimulus LFSR state

    `include "tb_util.svh"

    taillight_ctrl taillight_ctrl_i (
        .clk_en (clk_en),
        .rst    (rst),
        .left   (left),
        .right  (right),
        .la     (la),
        .lb     (lb),
        .lc     (lc),
        .ra     (ra),
        .rb     (rb),
        .rc     (rc)
    );

    // ============================================================
    // clock and cycle count
    // ============================================================

    initial clk_en = 1'b0;
    always #4 clk_en = ~clk_en;                    // 8 ns period

    // step ticks act on edges where cycle is a multiple of step_period
    always @(posedge clk_en) begin
        if (rst) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    // ============================================================
    // helpers
    // ============================================================

    function automatic logic [31:0] left_lamps();
        return {29'd0, lc, lb, la};                // la is bit 0, nearest the center
    endfunction

    function automatic logic [31:0] right_lamps();
        return {29'd0, rc, rb, ra};
    endfunction

    // expected lamps at each change of one sweep
    function automatic logic [31:0] sweep_pattern(input int step);
        case (step % 4)
            0:       return 32'h1;                 // inner lamp
            1:       return 32'h3;
            2:       return 32'h7;                 // all three lit
            default: return 32'h0;                 // dark step
        endcase
    endfunction

    // pending is set at edge press+1, the next tick edge takes it, lamps follow one edge later
    function automatic int first_lamp_cycle(input int press_cycle);
        int tick_edge;
        tick_edge = ((press_cycle + 2 + step_period - 1) / step_period) * step_period;
        return tick_edge + 1;
    endfunction

    task automatic step_cycles(input int count);
        repeat (count) begin
            @(posedge clk_en);
            #1;                                    // outputs settled, inputs driven here
        end
    endtask

    // one lamp change, exactly step_period after the previous one
    task automatic expect_step(
        input string test_name,
        input int    index,
        input int    start,
        input logic  on_left,
        input logic  on_right
    );
        wait_lamp_change(test_name);
        check_equal(test_name, start + step_period * index, cycle);
        check_equal(test_name, on_left ? sweep_pattern(index) : 32'h0, left_lamps());
        check_equal(test_name, on_right ? sweep_pattern(index) : 32'h0, right_lamps());
    endtask

    task automatic check_dark_for(input string test_name, input int count);
        repeat (count) begin
            step_cycles(1);
            check_equal(test_name, 32'h0, {26'd0, la, lb, lc, ra, rb, rc});
        end
    endtask

    task automatic pulse_turn(input logic on_left, input logic on_right);
        left  = on_left;
        right = on_right;
        step_cycles(1);                            // high for a single edge
        left  = 1'b0;
        right = 1'b0;
    endtask

    // a press seen on a tick edge starts by level and also queues a second sweep
    task automatic avoid_tick_edge();
        if ((cycle + 1) % step_period == 0) begin
            step_cycles(1);
        end
    endtask

    // ============================================================
    // directed tests
    // ============================================================

    task automatic test_reset_dark();
        check_dark_for("test_reset_dark", 4 * step_period);
    endtask

    task automatic test_left_sweep();
        int start;
        int i;
        avoid_tick_edge();
        start = first_lamp_cycle(cycle);
        pulse_turn(1'b1, 1'b0);
        for (i = 0; i < 4; i++) begin
            expect_step("test_left_sweep", i, start, 1'b1, 1'b0);
        end
        check_dark_for("test_left_sweep", 2 * step_period);
    endtask

    task automatic test_right_mirror();
        int delay;
        int bit_index;
        int start;
        int i;
        delay = 0;
        for (bit_index = 0; bit_index < 4; bit_index++) begin
            lfsr  = lfsr_next(lfsr);               // one step per bit
            delay = (delay << 1) | int'(lfsr[0]);
        end
        step_cycles(delay);                        // random timer phase
        avoid_tick_edge();
        start = first_lamp_cycle(cycle);
        pulse_turn(1'b0, 1'b1);
        for (i = 0; i < 4; i++) begin
            expect_step("test_right_mirror", i, start, 1'b0, 1'b1);
        end
        check_dark_for("test_right_mirror", 2 * step_period);
    endtask

    task automatic test_queued_press();
        int start;
        int i;
        avoid_tick_edge();
        start = first_lamp_cycle(cycle);
        pulse_turn(1'b1, 1'b0);
        for (i = 0; i < 8; i++) begin
            expect_step("test_queued_press", i, start, 1'b1, 1'b0);
            if (i == 1) begin
                pulse_turn(1'b1, 1'b0);            // second press while at 011
            end
        end
        check_dark_for("test_queued_press", 2 * step_period);
    endtask

    task automatic test_both_and_held();
        int start;
        int i;
        avoid_tick_edge();
        start = first_lamp_cycle(cycle);
        left  = 1'b1;
        right = 1'b1;
        for (i = 0; i < 12; i++) begin
            expect_step("test_both_and_held", i, start, 1'b1, 1'b1);
            if (i == 8) begin
                left  = 1'b0;                      // third sweep already running
                right = 1'b0;
            end
        end
        check_dark_for("test_both_and_held", 2 * step_period);
    endtask

    // ============================================================
    // run
    // ============================================================

    initial begin
        rst   = 1'b1;
        left  = 1'b0;
        right = 1'b0;
        lfsr  = lfsr_seed;
        step_cycles(2);                            // two edges in reset
        rst = 1'b0;
        test_reset_dark();
        test_left_sweep();
        test_right_mirror();
        test_queued_press();
        test_both_and_held();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* taillight_ctrl.f */
+incdir+include
verilog/taillight_timing_pkg.sv
verilog/taillight_lamp_pkg.sv
verilog/step_timer.sv
verilog/turn_request.sv
verilog/lamp_sequencer.sv
verilog/taillight_ctrl.sv
tests/taillight_ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= taillight_ctrl_tb
FILELIST  ?= taillight_ctrl.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
